//--- sw_top.f
logic/sw_pkg.sv
logic/sw_ctrl.sv
logic/sw_sweep_counter.sv
logic/sw_seq_store.sv
logic/sw_pe.sv
logic/sw_pe_array.sv
logic/sw_max_tracker.sv
logic/sw_top.sv
tests/sw_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the Smith-Waterman testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sw_top.f --top-module sw_tb -o sw_sim

./obj_dir/sw_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported failure"
    exit 1
fi

//--- tests/sw_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sw_tb import sw_pkg::*; ();

    // ------------------------------------------------------------------------
    // test table
    // ------------------------------------------------------------------------
    // gapped reuses the bases of the entry before it
    typedef enum logic [2:0] {
        K_IDENT,
        K_MISMATCH,
        K_RANDOM,
        K_GAPPED,
        K_NOISE
    } kind_t;

    // expected fields only used by the fixed kinds
    typedef struct packed {
        kind_t      kind;
        logic       gaps;
        score_t     score;
        ref_pos_t   ref_pos;
        query_pos_t query_pos;
    } entry_t;

    localparam int NUM_TESTS   = 8;
    // last load beat to finish_o, in cycles
    localparam int LATENCY     = STRIP_COUNT * SWEEP_CYCLES + 2;
    localparam int CYCLE_LIMIT = NUM_TESTS * (REF_LEN + LATENCY + 40);

    logic       clk = 1'b0;
    logic       reset;
    logic       valid_i;
    base_t      ref_base_i;
    base_t      query_base_i;
    logic       finish_o;
    pe_result_t result_o;

    entry_t      stim_table [NUM_TESTS];
    base_t       ref_seq [REF_LEN];
    base_t       query_seq [QUERY_LEN];
    logic [31:0] lfsr_state;
    int          test_errors;
    int          cycle_count = 0;

    always #20 clk = ~clk;

    sw_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .valid_i      (valid_i),
        .ref_base_i   (ref_base_i),
        .query_base_i (query_base_i),
        .finish_o     (finish_o),
        .result_o     (result_o)
    );

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // random bits
    // ------------------------------------------------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic string kind_name(input kind_t k);
        case (k)
            K_IDENT:    return "identical";
            K_MISMATCH: return "mismatch";
            K_RANDOM:   return "random";
            K_GAPPED:   return "valid gaps";
            default:    return "sweep noise";
        endcase
    endfunction

    function automatic int larger(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    task automatic make_bases(input kind_t kind);
        base_t q;
        for (int k = 0; k < REF_LEN; k++) begin
            ref_seq[k] = (kind == K_MISMATCH) ? 2'b00 : base_t'(rand_bits(2));
        end
        for (int k = 0; k < QUERY_LEN; k++) begin
            q = base_t'(rand_bits(2));
            case (kind)
                K_IDENT:    query_seq[k] = ref_seq[k];
                // never base 0, so nothing matches
                K_MISMATCH: query_seq[k] = (q == 2'b00) ? 2'b10 : q;
                default:    query_seq[k] = q;
            endcase
        end
    endtask

    // ------------------------------------------------------------------------
    // software model, affine gaps, one row kept at a time
    // ------------------------------------------------------------------------
    task automatic align_model(output score_t best_s, output ref_pos_t best_r,
                               output query_pos_t best_q);
        int h_up [REF_LEN+1];
        int i_up [REF_LEN+1];
        int h_left;
        int d_left;
        int diag;
        int sub;
        int i_val;
        int d_val;
        int h_val;
        int best;
        best   = 0;
        best_r = '0;
        best_q = '0;
        // top edge
        for (int j = 0; j <= REF_LEN; j++) begin
            h_up[j] = 0;
            i_up[j] = NEG_INF;
        end
        for (int i = 1; i <= QUERY_LEN; i++) begin
            // left edge
            h_left = 0;
            d_left = NEG_INF;
            diag   = 0;
            for (int j = 1; j <= REF_LEN; j++) begin
                sub   = (ref_seq[j-1] == query_seq[i-1]) ? MATCH_SCORE : MISMATCH_SCORE;
                i_val = larger(h_up[j] - GAP_OPEN, i_up[j] - GAP_EXTEND);
                d_val = larger(h_left - GAP_OPEN, d_left - GAP_EXTEND);
                h_val = larger(larger(0, diag + sub), larger(i_val, d_val));
                // query outer, ref inner, strict greater
                // so the first max seen has the lowest query then ref position
                if (h_val > best) begin
                    best   = h_val;
                    best_r = ref_pos_t'(j);
                    best_q = query_pos_t'(i);
                end
                diag    = h_up[j];
                h_up[j] = h_val;
                i_up[j] = i_val;
                h_left  = h_val;
                d_left  = d_val;
            end
        end
        best_s = score_t'(best);
    endtask

    // ------------------------------------------------------------------------
    // driving
    // ------------------------------------------------------------------------
    task automatic load_bases(input logic gaps);
        int k;
        k = 0;
        while (k < REF_LEN) begin
            @(posedge clk);
            #2;
            if (gaps && (rand_bits(2) == 32'd3)) begin
                // idle cycle with junk on the bases
                valid_i      = 1'b0;
                ref_base_i   = base_t'(rand_bits(2));
                query_base_i = base_t'(rand_bits(2));
            end else begin
                valid_i    = 1'b1;
                ref_base_i = ref_seq[k];
                // query beats past 48 should be dropped
                query_base_i = (k < QUERY_LEN) ? query_seq[k] : base_t'(rand_bits(2));
                k++;
            end
        end
    endtask

    // counts cycles from the last load beat, returns at the negedge
    task automatic wait_finish(input logic noise, output int lat);
        lat = 0;
        do begin
            @(posedge clk);
            #2;
            // noise stops well before the fsm is back in idle
            if (noise && (lat < STRIP_COUNT * SWEEP_CYCLES)) begin
                valid_i      = 1'b1;
                ref_base_i   = base_t'(rand_bits(2));
                query_base_i = base_t'(rand_bits(2));
            end else begin
                valid_i = 1'b0;
            end
            lat++;
            @(negedge clk);
        end while (!finish_o && (lat < LATENCY + 40));
    endtask

    task automatic check_score(input score_t got, input score_t exp);
        if (got !== exp) begin
            $display("Error: result_o.score = 0x%02h, expected 0x%02h", got, exp);
            test_errors++;
        end
    endtask

    task automatic check_ref_pos(input ref_pos_t got, input ref_pos_t exp);
        if (got !== exp) begin
            $display("Error: result_o.ref_pos = 0x%02h, expected 0x%02h", got, exp);
            test_errors++;
        end
    endtask

    task automatic check_query_pos(input query_pos_t got, input query_pos_t exp);
        if (got !== exp) begin
            $display("Error: result_o.query_pos = 0x%02h, expected 0x%02h", got, exp);
            test_errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        entry_t     entry;
        score_t     exp_score;
        ref_pos_t   exp_ref;
        query_pos_t exp_query;
        int         lat;
        int         passed;
        int         failed;
        reset        = 1'b1;
        valid_i      = 1'b0;
        ref_base_i   = '0;
        query_base_i = '0;
        lfsr_state   = 32'hbd77;
        passed       = 0;
        failed       = 0;

        stim_table = '{
            '{K_IDENT,    1'b0, 8'sd96, 7'd48, 6'd48},
            '{K_MISMATCH, 1'b0, '0, '0, '0},
            '{K_RANDOM,   1'b0, '0, '0, '0},
            '{K_GAPPED,   1'b1, '0, '0, '0},
            '{K_RANDOM,   1'b0, '0, '0, '0},
            '{K_NOISE,    1'b0, '0, '0, '0},
            '{K_IDENT,    1'b1, 8'sd96, 7'd48, 6'd48},
            '{K_RANDOM,   1'b1, '0, '0, '0}
        };

        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            entry       = stim_table[t];
            test_errors = 0;
            if (entry.kind != K_GAPPED) begin
                make_bases(entry.kind);
            end
            if ((entry.kind == K_IDENT) || (entry.kind == K_MISMATCH)) begin
                exp_score = entry.score;
                exp_ref   = entry.ref_pos;
                exp_query = entry.query_pos;
            end else begin
                align_model(exp_score, exp_ref, exp_query);
            end

            load_bases(entry.gaps);
            wait_finish(entry.kind == K_NOISE, lat);

            if (!finish_o) begin
                $display("finish_o did not rise within %0d cycles of the last beat", lat);
                test_errors++;
            end else if (lat != LATENCY) begin
                $display("finish_o rose %0d cycles after the last beat, expected %0d",
                         lat, LATENCY);
                test_errors++;
            end

            // result is valid in the finish cycle
            check_score(result_o.score, exp_score);
            check_ref_pos(result_o.ref_pos, exp_ref);
            check_query_pos(result_o.query_pos, exp_query);

            @(negedge clk);
            if (finish_o) begin
                $display("finish_o stayed high for more than one cycle");
                test_errors++;
            end

            $display("test %0d %s: %s", t, kind_name(entry.kind),
                     (test_errors == 0) ? "pass" : "fail");
            if (test_errors == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end

        $display("%0d tests, %0d passed, %0d failed", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/sw_top.sv
`timescale 1ns/1ps
`default_nettype none

module sw_top import sw_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       valid_i,
    input  base_t      ref_base_i,
    input  base_t      query_base_i,
    output logic       finish_o,
    output pe_result_t result_o
);

    logic                      load_en;
    logic                      sweep_en;
    logic                      load_done;
    logic                      sweep_done;
    logic                      strip_start;
    logic                      load_wr;
    logic                      tracker_clear;
    ref_pos_t                  beat;
    logic [6:0]                tick;
    logic [3:0]                strip;
    ref_pos_t                  ref_addr;
    ref_pos_t                  query_addr;
    base_t                     ref_rd;
    base_t                     query_rd;
    pe_result_t [PE_COUNT-1:0] pe_res;

    // beats outside the load phase never reach the stores
    assign load_wr       = valid_i && load_en;
    // new run, forget the previous best
    assign tracker_clear = strip_start && (strip == '0);

    sw_ctrl u_ctrl (
        .clk (clk), .reset (reset), .valid_i (valid_i),
        .load_done_i (load_done), .sweep_done_i (sweep_done),
        .load_en_o (load_en), .sweep_en_o (sweep_en), .finish_o (finish_o)
    );

    sw_sweep_counter u_counter (
        .clk (clk), .reset (reset), .valid_i (valid_i),
        .load_en_i (load_en), .sweep_en_i (sweep_en),
        .beat_o (beat), .tick_o (tick), .strip_o (strip),
        .load_done_o (load_done), .strip_start_o (strip_start),
        .sweep_done_o (sweep_done)
    );

    sw_seq_store #(.T (base_t), .DEPTH (REF_LEN)) u_ref_store (
        .clk (clk), .wr_en_i (load_wr), .wr_addr_i (beat), .wr_data_i (ref_base_i),
        .rd_addr_i (ref_addr), .rd_data_o (ref_rd)
    );

    sw_seq_store #(.T (base_t), .DEPTH (QUERY_LEN)) u_query_store (
        .clk (clk), .wr_en_i (load_wr), .wr_addr_i (beat), .wr_data_i (query_base_i),
        .rd_addr_i (query_addr), .rd_data_o (query_rd)
    );

    sw_pe_array u_array (
        .clk (clk), .reset (reset), .sweep_en_i (sweep_en), .strip_start_i (strip_start),
        .tick_i (tick), .strip_i (strip), .ref_base_i (ref_rd), .query_base_i (query_rd),
        .ref_addr_o (ref_addr), .query_addr_o (query_addr), .result_o (pe_res)
    );

    sw_max_tracker u_tracker (
        .clk (clk), .reset (reset), .clear_i (tracker_clear),
        .cand_i (pe_res), .best_o (result_o)
    );

endmodule

`default_nettype wire

//--- logic/sw_max_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module sw_max_tracker import sw_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear_i,
    input  pe_result_t [PE_COUNT-1:0] cand_i,
    output pe_result_t                best_o
);

    pe_result_t best_q;
    pe_result_t pick;

    // higher score, then lower query position, then lower reference position
    function automatic logic better(input pe_result_t a, input pe_result_t b);
        if (a.score != b.score) return a.score > b.score;
        if (a.query_pos != b.query_pos) return a.query_pos < b.query_pos;
        return a.ref_pos < b.ref_pos;
    endfunction

    // strict order, so scan order among the PEs does not matter
    always_comb begin
        pick = best_q;
        for (int k = 0; k < PE_COUNT; k++) begin
            if ((cand_i[k].query_pos != '0) && better(cand_i[k], pick)) begin
                pick = cand_i[k];
            end
        end
    end

    // cleared best is score 0 at 0/0, zero-score cells never beat it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            best_q <= '0;
        end else if (clear_i) begin
            best_q <= '0;
        end else begin
            best_q <= pick;
        end
    end

    assign best_o = best_q;

endmodule

`default_nettype wire

//--- logic/sw_pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module sw_pe_array import sw_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      sweep_en_i,
    input  logic                      strip_start_i,
    input  logic [6:0]                tick_i,
    input  logic [3:0]                strip_i,
    input  base_t                     ref_base_i,
    input  base_t                     query_base_i,
    output ref_pos_t                  ref_addr_o,
    output ref_pos_t                  query_addr_o,
    output pe_result_t [PE_COUNT-1:0] result_o
);

    pe_link_t   feed;
    pe_link_t   link [PE_COUNT+1];
    base_t      q_base_q [PE_COUNT];
    base_t      pe_qbase [PE_COUNT];
    query_pos_t pe_qpos [PE_COUNT];
    row_cell_t  row_rd;
    row_cell_t  row_wr;
    ref_pos_t   row_wr_addr;

    // ------------------------------------------------------------------------
    // addressing
    // ------------------------------------------------------------------------
    // column tick+1 enters PE0, reads past 64 come back zero
    assign ref_addr_o   = tick_i;
    // query base of row strip*4+k+1, fetched on tick k
    assign query_addr_o = ref_pos_t'(strip_i * PE_COUNT + tick_i % PE_COUNT);

    // PE k holds its base from tick k to the end of the strip
    always_ff @(posedge clk) begin
        for (int k = 0; k < PE_COUNT; k++) begin
            if (sweep_en_i && (tick_i == 7'(k))) begin
                q_base_q[k] <= query_base_i;
            end
        end
    end

    // ------------------------------------------------------------------------
    // PE0 feed
    // ------------------------------------------------------------------------
    always_comb begin
        feed.valid = sweep_en_i && (tick_i < REF_LEN);
        feed.first = strip_start_i;
        feed.base  = ref_base_i;
        // first strip sits on the matrix edge
        if (strip_i == '0) begin
            feed.h = '0;
            feed.i = NEG_INF;
        end else begin
            feed.h = row_rd.h;
            feed.i = row_rd.i;
        end
    end

    assign link[0] = feed;

    for (genvar k = 0; k < PE_COUNT; k++) begin : g_pe
        // live read data on the PE's first tick, register after that
        assign pe_qbase[k] = (tick_i == 7'(k)) ? query_base_i : q_base_q[k];
        assign pe_qpos[k]  = query_pos_t'(strip_i * PE_COUNT + k + 1);

        sw_pe u_pe (
            .clk          (clk),
            .reset        (reset),
            .link_i       (link[k]),
            .query_base_i (pe_qbase[k]),
            .query_pos_i  (pe_qpos[k]),
            .link_o       (link[k+1]),
            .result_o     (result_o[k])
        );
    end

    // ------------------------------------------------------------------------
    // boundary row, last PE of this strip to PE0 of the next
    // ------------------------------------------------------------------------
    assign row_wr.h    = link[PE_COUNT].h;
    assign row_wr.i    = link[PE_COUNT].i;
    assign row_wr_addr = result_o[PE_COUNT-1].ref_pos - 1'b1;

    sw_seq_store #(
        .T     (row_cell_t),
        .DEPTH (REF_LEN)
    ) u_row_store (
        .clk       (clk),
        .wr_en_i   (link[PE_COUNT].valid),
        .wr_addr_i (row_wr_addr),
        .wr_data_i (row_wr),
        .rd_addr_i (tick_i),
        .rd_data_o (row_rd)
    );

endmodule

`default_nettype wire

//--- logic/sw_pe.sv
`timescale 1ns/1ps
`default_nettype none

module sw_pe import sw_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  pe_link_t   link_i,
    input  base_t      query_base_i,
    input  query_pos_t query_pos_i,
    output pe_link_t   link_o,
    output pe_result_t result_o
);

    // previous column of this row
    score_t   diag_q;
    score_t   left_h_q;
    score_t   left_d_q;
    ref_pos_t col_q;

    score_t   diag;
    score_t   left_h;
    score_t   left_d;
    score_t   sub;
    score_t   diag_sum;
    score_t   i_new;
    score_t   d_new;
    score_t   h_new;
    ref_pos_t col;

    // ------------------------------------------------------------------------
    // cell recurrence
    // ------------------------------------------------------------------------
    always_comb begin
        // column 1 sees the matrix edge on the left
        diag   = link_i.first ? '0 : diag_q;
        left_h = link_i.first ? '0 : left_h_q;
        left_d = link_i.first ? NEG_INF : left_d_q;
        col    = link_i.first ? ref_pos_t'(1) : col_q + 1'b1;

        sub = (link_i.base == query_base_i) ? MATCH_SCORE : MISMATCH_SCORE;

        // gap from above
        if (link_i.h - GAP_OPEN > link_i.i - GAP_EXTEND)
            i_new = link_i.h - GAP_OPEN;
        else
            i_new = link_i.i - GAP_EXTEND;

        // gap from the left
        if (left_h - GAP_OPEN > left_d - GAP_EXTEND)
            d_new = left_h - GAP_OPEN;
        else
            d_new = left_d - GAP_EXTEND;

        // floor at zero
        diag_sum = diag + sub;
        h_new    = '0;
        if (diag_sum > h_new) h_new = diag_sum;
        if (i_new > h_new) h_new = i_new;
        if (d_new > h_new) h_new = d_new;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            link_o   <= '0;
            result_o <= '0;
            col_q    <= '0;
        end else begin
            link_o.valid <= link_i.valid;
            link_o.first <= link_i.first;
            link_o.base  <= link_i.base;
            link_o.h     <= h_new;
            link_o.i     <= i_new;
            result_o     <= '0;
            if (link_i.valid) begin
                col_q              <= col;
                result_o.score     <= h_new;
                result_o.ref_pos   <= col;
                result_o.query_pos <= query_pos_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (link_i.valid) begin
            diag_q   <= link_i.h;
            left_h_q <= h_new;
            left_d_q <= d_new;
        end
    end

    a_h_non_negative: assert property (@(posedge clk) disable iff (reset)
        link_i.valid |=> result_o.score >= 0);

endmodule

`default_nettype wire

//--- logic/sw_seq_store.sv
`timescale 1ns/1ps
`default_nettype none

module sw_seq_store import sw_pkg::*; #(
    parameter type T     = base_t,
    parameter int  DEPTH = REF_LEN
) (
    input  logic     clk,
    input  logic     wr_en_i,
    input  ref_pos_t wr_addr_i,
    input  T         wr_data_i,
    input  ref_pos_t rd_addr_i,
    output T         rd_data_o
);

    localparam int AW = $clog2(DEPTH);

    T mem [DEPTH];

    // writes past the end are dropped, so extra query beats vanish here
    always_ff @(posedge clk) begin
        if (wr_en_i && (wr_addr_i < DEPTH)) begin
            mem[wr_addr_i[AW-1:0]] <= wr_data_i;
        end
    end

    // combinational read, zero outside the array
    assign rd_data_o = (rd_addr_i < DEPTH) ? mem[rd_addr_i[AW-1:0]] : '0;

endmodule

`default_nettype wire

//--- logic/sw_sweep_counter.sv
`timescale 1ns/1ps
`default_nettype none

module sw_sweep_counter import sw_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       valid_i,
    input  logic       load_en_i,
    input  logic       sweep_en_i,
    output ref_pos_t   beat_o,
    output logic [6:0] tick_o,
    output logic [3:0] strip_o,
    output logic       load_done_o,
    output logic       strip_start_o,
    output logic       sweep_done_o
);

    ref_pos_t   beat_q;
    logic [6:0] tick_q;
    logic [3:0] strip_q;
    logic       last_tick;

    assign last_tick     = (tick_q == 7'(SWEEP_CYCLES - 1));
    assign load_done_o   = load_en_i && valid_i && (beat_q == ref_pos_t'(REF_LEN - 1));
    assign strip_start_o = sweep_en_i && (tick_q == '0);
    assign sweep_done_o  = sweep_en_i && last_tick && (strip_q == 4'(STRIP_COUNT - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            beat_q  <= '0;
            tick_q  <= '0;
            strip_q <= '0;
        end else if (load_en_i) begin
            // beat wraps on the last beat, ready for the next run
            if (valid_i) begin
                beat_q <= load_done_o ? '0 : beat_q + 1'b1;
            end
            tick_q  <= '0;
            strip_q <= '0;
        end else if (sweep_en_i) begin
            if (last_tick) begin
                tick_q  <= '0;
                strip_q <= sweep_done_o ? '0 : strip_q + 1'b1;
            end else begin
                tick_q <= tick_q + 1'b1;
            end
        end else begin
            // idle or done, rewind everything
            beat_q  <= '0;
            tick_q  <= '0;
            strip_q <= '0;
        end
    end

    assign beat_o  = beat_q;
    assign tick_o  = tick_q;
    assign strip_o = strip_q;

    a_strip_range: assert property (@(posedge clk) disable iff (reset)
        sweep_en_i |=> strip_o < STRIP_COUNT);

endmodule

`default_nettype wire

//--- logic/sw_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sw_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic valid_i,
    input  logic load_done_i,
    input  logic sweep_done_i,
    output logic load_en_o,
    output logic sweep_en_o,
    output logic finish_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SWEEP,
        ST_DONE
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   finish_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (valid_i) state_d = ST_LOAD;
            ST_LOAD:  if (load_done_i) state_d = ST_SWEEP;
            ST_SWEEP: if (sweep_done_i) state_d = ST_DONE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q  <= ST_IDLE;
            finish_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            // one more cycle so the last max update has landed
            finish_q <= (state_q == ST_DONE);
        end
    end

    // idle takes the opening beat of a run, only while it is valid
    assign load_en_o  = (state_q == ST_LOAD) || ((state_q == ST_IDLE) && valid_i);
    assign sweep_en_o = (state_q == ST_SWEEP);
    assign finish_o   = finish_q;

    a_finish_single: assert property (@(posedge clk) disable iff (reset)
        finish_o |=> !finish_o);
    a_phase_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(load_en_o && sweep_en_o));

endmodule

`default_nettype wire

//--- logic/sw_pkg.sv
`default_nettype none

package sw_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------
    localparam int REF_LEN      = 64;
    localparam int QUERY_LEN    = 48;
    localparam int PE_COUNT     = 4;
    localparam int STRIP_COUNT  = QUERY_LEN / PE_COUNT;
    // ticks per strip, pipeline fill included
    localparam int SWEEP_CYCLES = REF_LEN + PE_COUNT - 1;

    typedef logic [1:0]        base_t;
    typedef logic signed [7:0] score_t;
    // positions are one based, 0 means no cell
    typedef logic [6:0]        ref_pos_t;
    typedef logic [5:0]        query_pos_t;

    // ------------------------------------------------------------------------
    // affine gap scoring
    // ------------------------------------------------------------------------
    localparam score_t MATCH_SCORE    = 8'sd2;
    localparam score_t MISMATCH_SCORE = -8'sd1;
    localparam score_t GAP_OPEN       = 8'sd2;
    localparam score_t GAP_EXTEND     = 8'sd1;
    // gap value above row 1 and left of column 1
    localparam score_t NEG_INF        = -8'sd32;

    // bottom row of a strip, kept for the next strip
    typedef struct packed {
        score_t h;
        score_t i;
    } row_cell_t;

    // one PE to the next
    typedef struct packed {
        logic   valid;
        logic   first;   // column 1 of the strip
        base_t  base;    // reference base of this column
        score_t h;       // upper H for the next row
        score_t i;       // upper I for the next row
    } pe_link_t;

    // all zero when the PE had no cell
    typedef struct packed {
        score_t     score;
        ref_pos_t   ref_pos;
        query_pos_t query_pos;
    } pe_result_t;

endpackage

`default_nettype wire
